// ==== rtl/axi_pkg.sv ====
// AXI4 protocol facts for the read master
//   Address and data bus widths with their word types
//   Burst length field type
//   Beat size and the 4 KB burst boundary
package axi_pkg;

  // Bus widths
  localparam int addr_w = 32;
  localparam int data_w = 64;

  // AxLEN holds the beat count minus one
  localparam int len_w = 8;

  // Bytes moved by one data beat
  localparam int bytes_per_beat = data_w / 8;

  // No burst may cross this address boundary
  localparam int max_burst_bytes = 4096;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [len_w-1:0]  len_t;

endpackage

// ==== rtl/rdm_pkg.sv ====
// Read master configuration
//   Burst size, outstanding limit and FIFO depth
//   Widths derived from them and the matching types
//   Address issue FSM states
package rdm_pkg;

  ////////////////////
  // Configuration
  ////////////////////
  localparam int burst_beats     = 16;
  localparam int max_outstanding = 4;
  // Room for every beat that the credits allow in flight
  localparam int fifo_depth      = burst_beats * max_outstanding;

  ////////////////////
  // Derived widths
  ////////////////////
  localparam int size_w      = 32;
  localparam int beat_lsb    = $clog2(axi_pkg::bytes_per_beat);
  localparam int beats_w     = size_w - beat_lsb;
  localparam int len_lsb     = $clog2(burst_beats);
  localparam int burst_cnt_w = 28;
  localparam int credit_w    = $clog2(max_outstanding + 1);
  localparam int fifo_aw     = $clog2(fifo_depth);
  // Extra bit tells full from empty
  localparam int fifo_ptr_w  = fifo_aw + 1;

  // Bytes covered by one full burst, 128
  localparam int burst_bytes = burst_beats * axi_pkg::bytes_per_beat;
  localparam axi_pkg::addr_t burst_stride    = axi_pkg::addr_t'(burst_bytes);
  localparam axi_pkg::addr_t burst_addr_mask = axi_pkg::addr_t'(burst_bytes - 1);
  localparam axi_pkg::len_t  full_len        = axi_pkg::len_t'(burst_beats - 1);

  typedef logic [size_w-1:0]      size_t;
  typedef logic [beats_w-1:0]     beats_t;
  typedef logic [burst_cnt_w-1:0] burst_cnt_t;
  typedef logic [credit_w-1:0]    credit_t;
  typedef logic [fifo_ptr_w-1:0]  fifo_ptr_t;

  // Address issue FSM
  typedef enum logic [1:0] {
    idle,
    issue,
    stall
  } ar_state_e;

endpackage

// ==== rtl/rdm_job_if.sv ====
// Read job handed from command capture to the later stages
//   Load strobe with the aligned base address
//   Burst count minus one and the length of the final burst
`timescale 1ns/1ps

interface rdm_job_if;

  // One cycle strobe, fields are valid with it and held after
  logic                load;
  axi_pkg::addr_t      base_addr;
  // Number of bursts minus one
  rdm_pkg::burst_cnt_t num_bursts;
  // AxLEN of the last burst
  axi_pkg::len_t       final_len;

  modport capture (output load, output base_addr, output num_bursts, output final_len);

  // Address issue needs the whole job
  modport ar (input load, input base_addr, input num_bursts, input final_len);

  // Response tracking only counts bursts
  modport r (input load, input num_bursts);

endinterface

// ==== rtl/rdm_cmd_capture.sv ====
// Command capture stage
//   Samples start address and byte count on ctrl_start
//   Rounds the count up to whole beats, aligns the address down
//   Splits the job into bursts and strobes load two cycles later
`timescale 1ns/1ps

module rdm_cmd_capture (
  input  logic            aclk,
  input  logic            areset,
  input  logic            ctrl_start,
  input  axi_pkg::addr_t  ctrl_addr_offset,
  input  rdm_pkg::size_t  ctrl_xfer_size_in_bytes,
  rdm_job_if.capture      job
);

  logic            start_d1;
  axi_pkg::addr_t  addr_r;
  // Total beats minus one
  rdm_pkg::beats_t beats_m1;

  ////////////////////
  // Start strobe
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      job.load <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      job.load <= start_d1;
    end
  end

  // First cycle: round and align
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      addr_r <= ctrl_addr_offset & ~rdm_pkg::burst_addr_mask;
      // A partial last beat counts as a whole beat
      if (|ctrl_xfer_size_in_bytes[rdm_pkg::beat_lsb-1:0]) begin
        beats_m1 <= ctrl_xfer_size_in_bytes[rdm_pkg::size_w-1:rdm_pkg::beat_lsb];
      end else begin
        beats_m1 <= ctrl_xfer_size_in_bytes[rdm_pkg::size_w-1:rdm_pkg::beat_lsb] - 1'b1;
      end
    end
  end

  // Second cycle: split into bursts
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      job.base_addr  <= addr_r;
      // Upper bits of beats minus one give bursts minus one
      job.num_bursts <= rdm_pkg::burst_cnt_t'(beats_m1[rdm_pkg::beats_w-1:rdm_pkg::len_lsb]);
      // Low bits give the final burst length
      job.final_len  <= axi_pkg::len_t'(beats_m1[rdm_pkg::len_lsb-1:0]);
    end
  end

endmodule

// ==== rtl/rdm_ar_issue.sv ====
// Read address channel sequencing
//   FSM over idle, issue and stall
//   Address counter stepping one burst per accepted address
//   Burst countdown selecting the final burst length
//   Outstanding credit counter, spent on AR and returned on stream tlast
`timescale 1ns/1ps

module rdm_ar_issue (
  input  logic           aclk,
  input  logic           areset,
  rdm_job_if.ar          job,
  input  logic           credit_return,
  output logic           arvalid,
  input  logic           arready,
  output axi_pkg::addr_t araddr,
  output axi_pkg::len_t  arlen
);

  rdm_pkg::ar_state_e  state;
  rdm_pkg::burst_cnt_t bursts_left;
  rdm_pkg::credit_t    credits;
  logic                arxfer;
  logic                final_burst;
  logic                have_credit;

  assign arxfer      = arvalid & arready;
  assign final_burst = (bursts_left == '0);
  assign have_credit = (credits != '0);

  // Counter only moves on accept, so arlen holds while arvalid waits
  assign arlen = final_burst ? job.final_len : rdm_pkg::full_len;

  ////////////////////
  // FSM and arvalid
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      state   <= rdm_pkg::idle;
      arvalid <= 1'b0;
    end else begin
      case (state)
        rdm_pkg::idle: begin
          if (job.load) begin
            state <= rdm_pkg::issue;
          end
        end
        rdm_pkg::issue: begin
          if (arxfer) begin
            // One idle cycle between addresses
            arvalid <= 1'b0;
            if (final_burst) begin
              state <= rdm_pkg::idle;
            end
          end else if (!arvalid) begin
            if (have_credit) begin
              arvalid <= 1'b1;
            end else begin
              state <= rdm_pkg::stall;
            end
          end
        end
        rdm_pkg::stall: begin
          // Wait here until a burst drains from the stream side
          if (have_credit) begin
            arvalid <= 1'b1;
            state   <= rdm_pkg::issue;
          end
        end
        default: begin
          state   <= rdm_pkg::idle;
          arvalid <= 1'b0;
        end
      endcase
    end
  end

  ////////////////////
  // Address counter
  ////////////////////
  always_ff @(posedge aclk) begin
    if (job.load) begin
      araddr <= job.base_addr;
    end else if (arxfer) begin
      araddr <= araddr + rdm_pkg::burst_stride;
    end
  end

  // Burst countdown, stops at zero on the final burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (job.load) begin
      bursts_left <= job.num_bursts;
    end else if (arxfer && !final_burst) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  ////////////////////
  // Credits
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= rdm_pkg::credit_t'(rdm_pkg::max_outstanding);
    end else begin
      case ({arxfer, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        // Spend and return together cancel
        default: credits <= credits;
      endcase
    end
  end

endmodule

// ==== rtl/rdm_r_track.sv ====
// Read data channel tracking
//   Counts bursts finished by an accepted rlast
//   Pulses ctrl_done for one cycle after the final burst
`timescale 1ns/1ps

module rdm_r_track (
  input  logic  aclk,
  input  logic  areset,
  rdm_job_if.r  job,
  input  logic  rvalid,
  input  logic  rlast,
  output logic  ctrl_done
);

  rdm_pkg::burst_cnt_t bursts_left;
  logic                busy;
  logic                burst_end;

  // rready is tied high, so rvalid alone means accepted
  assign burst_end = rvalid & rlast;

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
      busy        <= 1'b0;
      ctrl_done   <= 1'b0;
    end else begin
      // Default low keeps the pulse to a single cycle
      ctrl_done <= 1'b0;
      if (job.load) begin
        bursts_left <= job.num_bursts;
        busy        <= 1'b1;
      end else if (busy && burst_end) begin
        if (bursts_left == '0) begin
          // Last rlast of the job
          busy      <= 1'b0;
          ctrl_done <= 1'b1;
        end else begin
          bursts_left <= bursts_left - 1'b1;
        end
      end
    end
  end

endmodule

// ==== rtl/rdm_data_fifo.sv ====
// Read data buffer
//   Memory of fifo_depth beats, each with its last flag
//   Registered first-word-fall-through stream output
//   Bypass into the output register when the memory is empty
//   Credit return pulse on each stream beat with tlast
`timescale 1ns/1ps

module rdm_data_fifo (
  input  logic           aclk,
  input  logic           areset,
  input  logic           rvalid,
  input  logic           rlast,
  input  axi_pkg::data_t rdata,
  output logic           tvalid,
  input  logic           tready,
  output logic           tlast,
  output axi_pkg::data_t tdata,
  output logic           credit_return
);

  axi_pkg::data_t     mem_data [rdm_pkg::fifo_depth];
  logic               mem_last [rdm_pkg::fifo_depth];
  rdm_pkg::fifo_ptr_t wr_ptr;
  rdm_pkg::fifo_ptr_t rd_ptr;
  logic               mem_empty;
  logic               out_free;
  logic               take_mem;
  logic               bypass;
  logic               push;

  assign mem_empty = (wr_ptr == rd_ptr);
  // Output register can take a new beat this cycle
  assign out_free  = !tvalid || tready;
  assign take_mem  = out_free && !mem_empty;
  // Skip the memory so a beat shows up one cycle after rvalid
  assign bypass    = out_free && mem_empty && rvalid;
  assign push      = rvalid && !bypass;

  ////////////////////
  // Storage
  ////////////////////
  always_ff @(posedge aclk) begin
    if (push) begin
      mem_data[wr_ptr[rdm_pkg::fifo_aw-1:0]] <= rdata;
      mem_last[wr_ptr[rdm_pkg::fifo_aw-1:0]] <= rlast;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take_mem) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////
  // Stream output
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      tvalid <= 1'b0;
    end else if (out_free) begin
      tvalid <= take_mem || bypass;
    end
  end

  // Payload only changes when the register is free, so it holds under stall
  always_ff @(posedge aclk) begin
    if (take_mem) begin
      tdata <= mem_data[rd_ptr[rdm_pkg::fifo_aw-1:0]];
      tlast <= mem_last[rd_ptr[rdm_pkg::fifo_aw-1:0]];
    end else if (bypass) begin
      tdata <= rdata;
      tlast <= rlast;
    end
  end

  // A whole burst has left the master
  assign credit_return = tvalid & tready & tlast;

endmodule

// ==== rtl/axi_read_master.sv ====
// AXI4 read master top level
//   Command capture, address issue, response tracking, data buffer
//   Plain AXI read channel and stream ports
`timescale 1ns/1ps

module axi_read_master (
  input  logic           aclk,
  input  logic           areset,
  // Control
  input  logic           ctrl_start,
  output logic           ctrl_done,
  input  axi_pkg::addr_t ctrl_addr_offset,
  input  rdm_pkg::size_t ctrl_xfer_size_in_bytes,
  // AXI4 read address channel
  output logic           m_axi_arvalid,
  input  logic           m_axi_arready,
  output axi_pkg::addr_t m_axi_araddr,
  output axi_pkg::len_t  m_axi_arlen,
  // AXI4 read data channel
  input  logic           m_axi_rvalid,
  output logic           m_axi_rready,
  input  axi_pkg::data_t m_axi_rdata,
  input  logic           m_axi_rlast,
  // Stream output
  output logic           m_axis_tvalid,
  input  logic           m_axis_tready,
  output axi_pkg::data_t m_axis_tdata,
  output logic           m_axis_tlast
);

  rdm_job_if job ();
  logic      credit_return;

  // Credits keep FIFO room for every outstanding beat
  assign m_axi_rready = 1'b1;

  rdm_cmd_capture u_cmd_capture (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .job                     (job.capture)
  );

  rdm_ar_issue u_ar_issue (
    .aclk          (aclk),
    .areset        (areset),
    .job           (job.ar),
    .credit_return (credit_return),
    .arvalid       (m_axi_arvalid),
    .arready       (m_axi_arready),
    .araddr        (m_axi_araddr),
    .arlen         (m_axi_arlen)
  );

  rdm_r_track u_r_track (
    .aclk      (aclk),
    .areset    (areset),
    .job       (job.r),
    .rvalid    (m_axi_rvalid),
    .rlast     (m_axi_rlast),
    .ctrl_done (ctrl_done)
  );

  rdm_data_fifo u_data_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .rvalid        (m_axi_rvalid),
    .rlast         (m_axi_rlast),
    .rdata         (m_axi_rdata),
    .tvalid        (m_axis_tvalid),
    .tready        (m_axis_tready),
    .tlast         (m_axis_tlast),
    .tdata         (m_axis_tdata),
    .credit_return (credit_return)
  );

endmodule

// ==== verif/axi_read_master_asserts.sv ====
// Protocol assertions bound into the read master
//   AR payload held while arvalid waits
//   Stream payload held while tvalid waits
//   No accepted burst crosses a 4 KB boundary
//   ctrl_done is a single cycle pulse
`timescale 1ns/1ps

module axi_read_master_asserts (
  input logic           aclk,
  input logic           areset,
  input logic           m_axi_arvalid,
  input logic           m_axi_arready,
  input axi_pkg::addr_t m_axi_araddr,
  input axi_pkg::len_t  m_axi_arlen,
  input logic           m_axis_tvalid,
  input logic           m_axis_tready,
  input axi_pkg::data_t m_axis_tdata,
  input logic           m_axis_tlast,
  input logic           ctrl_done
);

  // Stalled address must not move
  ar_hold : assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else $error("AR payload changed while arvalid was stalled");

  // Stalled stream beat must not move
  t_hold : assert property (@(posedge aclk) disable iff (areset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else $error("Stream payload changed while tvalid was stalled");

  // Offset in the 4 KB page plus burst bytes stays inside the page
  ar_4k : assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && m_axi_arready |->
      (int'(m_axi_araddr % axi_pkg::max_burst_bytes)
        + (int'(m_axi_arlen) + 1) * axi_pkg::bytes_per_beat) <= axi_pkg::max_burst_bytes)
    else $error("Accepted burst crosses a 4 KB boundary");

  done_pulse : assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done stayed high for more than one cycle");

endmodule

// ==== verif/tb_axi_read_master.sv ====
// Testbench for the AXI4 read master
//   Clock, reset and job sequencing from the golden file
//   In-order memory slave with random AR, R and stream stalls
//   Typed compare tasks, outstanding burst tracking, watchdog
`timescale 1ns/1ps

module tb_axi_read_master;

  localparam int          max_jobs   = 16;
  localparam int          beat_bytes = 8;
  localparam int          burst_len  = 16;
  localparam int          max_out    = 4;
  // Bursts start on 128 byte boundaries
  localparam logic [31:0] align_mask = 32'h0000_007f;

  logic           aclk;
  logic           areset;
  logic           ctrl_start;
  logic           ctrl_done;
  axi_pkg::addr_t ctrl_addr_offset;
  rdm_pkg::size_t ctrl_xfer_size_in_bytes;
  logic           m_axi_arvalid;
  logic           m_axi_arready;
  axi_pkg::addr_t m_axi_araddr;
  axi_pkg::len_t  m_axi_arlen;
  logic           m_axi_rvalid;
  logic           m_axi_rready;
  axi_pkg::data_t m_axi_rdata;
  logic           m_axi_rlast;
  logic           m_axis_tvalid;
  logic           m_axis_tready;
  axi_pkg::data_t m_axis_tdata;
  logic           m_axis_tlast;

  // Four words per job
  logic [31:0]    golden [0:4*max_jobs-1];
  // Expectations and progress of the running job
  axi_pkg::addr_t exp_base;
  int             exp_bursts;
  int             exp_beats;
  int             ar_count;
  int             beat_count;
  int             rlast_count;
  int             done_count;
  // Bursts accepted on AR and not yet closed by stream tlast
  int             outstanding;
  int             value_errors;
  int             other_errors;
  int             cycle_count;
  int             timeout_limit;
  logic [31:0]    rng_state;
  // Slave side
  axi_pkg::addr_t ar_addr_q [$];
  axi_pkg::len_t  ar_len_q [$];
  axi_pkg::addr_t r_addr;
  int             r_left;
  logic           r_active;
  int             tready_stall;

  axi_read_master dut (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_done               (ctrl_done),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .m_axi_arvalid           (m_axi_arvalid),
    .m_axi_arready           (m_axi_arready),
    .m_axi_araddr            (m_axi_araddr),
    .m_axi_arlen             (m_axi_arlen),
    .m_axi_rvalid            (m_axi_rvalid),
    .m_axi_rready            (m_axi_rready),
    .m_axi_rdata             (m_axi_rdata),
    .m_axi_rlast             (m_axi_rlast),
    .m_axis_tvalid           (m_axis_tvalid),
    .m_axis_tready           (m_axis_tready),
    .m_axis_tdata            (m_axis_tdata),
    .m_axis_tlast            (m_axis_tlast)
  );

  bind axi_read_master axi_read_master_asserts u_asserts (
    .aclk          (aclk),
    .areset        (areset),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .ctrl_done     (ctrl_done)
  );

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_addr(input string name, input axi_pkg::addr_t got,
                            input axi_pkg::addr_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input axi_pkg::len_t got,
                           input axi_pkg::len_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input axi_pkg::data_t got,
                            input axi_pkg::data_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Burst and beat counts
  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      value_errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Random stalls
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  ////////////////////
  // Monitors
  ////////////////////
  // Address index within the job gives both the expected address and length
  task automatic record_address();
    axi_pkg::addr_t exp_addr;
    axi_pkg::len_t  exp_len;
    ar_addr_q.push_back(m_axi_araddr);
    ar_len_q.push_back(m_axi_arlen);
    outstanding++;
    if (outstanding > max_out) begin
      other_errors++;
      $display("More than %0d bursts outstanding at %0t", max_out, $time);
    end
    if (ar_count >= exp_bursts) begin
      other_errors++;
      $display("Read address at %0t goes beyond the bursts of the job", $time);
    end else begin
      exp_addr = exp_base + axi_pkg::addr_t'(ar_count * burst_len * beat_bytes);
      if (ar_count == exp_bursts - 1) begin
        exp_len = axi_pkg::len_t'((exp_beats - 1) % burst_len);
      end else begin
        exp_len = axi_pkg::len_t'(burst_len - 1);
      end
      check_addr("m_axi_araddr", m_axi_araddr, exp_addr);
      check_len("m_axi_arlen", m_axi_arlen, exp_len);
    end
    ar_count++;
  endtask

  // Data is the byte address and tlast marks every 16th and the final beat
  task automatic check_stream_beat();
    axi_pkg::data_t exp_data;
    logic           exp_last;
    if (beat_count >= exp_beats) begin
      other_errors++;
      $display("Stream beat at %0t arrived after the last beat of the job", $time);
    end else begin
      exp_data = axi_pkg::data_t'(exp_base + axi_pkg::addr_t'(beat_count * beat_bytes));
      exp_last = ((beat_count % burst_len) == burst_len - 1) || (beat_count == exp_beats - 1);
      check_data("m_axis_tdata", m_axis_tdata, exp_data);
      check_flag("m_axis_tlast", m_axis_tlast, exp_last);
    end
    beat_count++;
    if (m_axis_tlast) begin
      outstanding--;
    end
  endtask

  ////////////////////
  // Memory slave
  ////////////////////
  // Called just after the edge with the R handshake that it completed
  task automatic drive_slave(input logic r_fire);
    logic [31:0] rnd;
    rnd = next_random();
    m_axi_arready = (rnd[1:0] != 2'b00);
    if (r_fire) begin
      r_addr = r_addr + axi_pkg::addr_t'(beat_bytes);
      r_left--;
      if (r_left == 0) begin
        r_active = 1'b0;
      end
    end
    // Answer addresses in the order they were accepted
    if (!r_active && ar_addr_q.size() > 0) begin
      r_addr   = ar_addr_q.pop_front();
      r_left   = int'(ar_len_q.pop_front()) + 1;
      r_active = 1'b1;
    end
    if (r_active && rnd[3:2] != 2'b00) begin
      m_axi_rvalid = 1'b1;
      m_axi_rdata  = axi_pkg::data_t'(r_addr);
      m_axi_rlast  = (r_left == 1);
    end else begin
      m_axi_rvalid = 1'b0;
      m_axi_rlast  = 1'b0;
    end
    // Rare long stalls fill the FIFO and run the credits down
    if (tready_stall > 0) begin
      tready_stall--;
      m_axis_tready = 1'b0;
    end else if (rnd[9:4] == 6'd0) begin
      tready_stall  = 30 + int'(rnd[15:10]);
      m_axis_tready = 1'b0;
    end else begin
      m_axis_tready = (rnd[17:16] != 2'b00);
    end
  endtask

  // Sample at the falling edge and drive 1 ns after the rising edge
  initial begin : bus_model
    logic ar_fire;
    logic r_fire;
    logic t_fire;
    rng_state     = 32'd38812;
    r_addr        = '0;
    r_left        = 0;
    r_active      = 1'b0;
    tready_stall  = 0;
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_rdata   = '0;
    m_axi_rlast   = 1'b0;
    m_axis_tready = 1'b0;
    forever begin
      @(negedge aclk);
      ar_fire = m_axi_arvalid && m_axi_arready;
      r_fire  = m_axi_rvalid && m_axi_rready;
      t_fire  = m_axis_tvalid && m_axis_tready;
      if (!areset) begin
        // The master always accepts read data
        check_flag("m_axi_rready", m_axi_rready, 1'b1);
        // Stream tlast goes first so that a credit return and spend in one cycle cancel
        if (t_fire) begin
          check_stream_beat();
        end
        if (ar_fire) begin
          record_address();
        end
        if (r_fire && m_axi_rlast) begin
          rlast_count++;
        end
        if (ctrl_done) begin
          done_count++;
          check_count("rlast beats before ctrl_done", rlast_count, exp_bursts);
        end
      end
      @(posedge aclk);
      #1;
      drive_slave(r_fire);
    end
  end

  ////////////////////
  // Job sequencing
  ////////////////////
  task automatic run_job(input axi_pkg::addr_t addr, input rdm_pkg::size_t bytes,
                         input int bursts, input int beats);
    exp_base    = addr & ~align_mask;
    exp_bursts  = bursts;
    exp_beats   = beats;
    ar_count    = 0;
    beat_count  = 0;
    rlast_count = 0;
    done_count  = 0;
    @(posedge aclk);
    #1;
    ctrl_start              = 1'b1;
    ctrl_addr_offset        = addr;
    ctrl_xfer_size_in_bytes = bytes;
    @(posedge aclk);
    #1;
    ctrl_start = 1'b0;
    while (done_count == 0) begin
      @(posedge aclk);
    end
    // Data may still sit in the FIFO after ctrl_done
    while (beat_count < exp_beats) begin
      @(posedge aclk);
    end
    // Gives a stray beat or second pulse time to show up
    repeat (4) @(posedge aclk);
    check_count("read address bursts", ar_count, exp_bursts);
    check_count("stream beats", beat_count, exp_beats);
    check_count("ctrl_done pulses", done_count, 1);
    check_count("outstanding bursts at job end", outstanding, 0);
  endtask

  initial begin : main
    int n_jobs;
    int total_beats;
    int j;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    exp_base                = '0;
    exp_bursts              = 0;
    exp_beats               = 0;
    outstanding             = 0;
    value_errors            = 0;
    other_errors            = 0;
    timeout_limit           = 0;
    for (j = 0; j < 4 * max_jobs; j++) begin
      golden[j] = '0;
    end
    $readmemh("verif/rdm_golden.txt", golden);
    // A zero byte count ends the job list
    n_jobs      = 0;
    total_beats = 0;
    while (n_jobs < max_jobs && golden[4*n_jobs+1] != 32'd0) begin
      total_beats += int'(golden[4*n_jobs+3]);
      n_jobs++;
    end
    if (n_jobs == 0) begin
      other_errors++;
      $display("No jobs could be read from the golden file");
    end
    timeout_limit = 40 * total_beats + 200;
    repeat (4) @(posedge aclk);
    #1;
    areset = 1'b0;
    for (j = 0; j < n_jobs; j++) begin
      run_job(golden[4*j], golden[4*j+1], int'(golden[4*j+2]), int'(golden[4*j+3]));
    end
    $display("Summary: %0d value mismatches, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog over the whole run
  initial begin : watchdog
    cycle_count = 0;
    wait (timeout_limit > 0);
    while (cycle_count < timeout_limit) begin
      @(posedge aclk);
      cycle_count++;
    end
    $display("Timeout, the run did not finish within %0d cycles", timeout_limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/axi_pkg.sv
rtl/rdm_pkg.sv
rtl/rdm_job_if.sv
rtl/rdm_cmd_capture.sv
rtl/rdm_ar_issue.sv
rtl/rdm_r_track.sv
rtl/rdm_data_fifo.sv
rtl/axi_read_master.sv
verif/axi_read_master_asserts.sv
verif/tb_axi_read_master.sv

// ==== run.sh ====
#!/bin/sh
# Build the AXI read master testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  -f tb.f \
  --top-module tb_axi_read_master \
  -Mdir obj_dir

# The simulator may exit non-zero on an assertion, so the verdict comes from the output
sim_out=$(./obj_dir/Vtb_axi_read_master) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "TEST PASSED"; then
  exit 0
else
  exit 1
fi

// ==== verif/rdm_golden.txt ====
// Columns in hex: start address, byte count, expected bursts, expected beats
// One job per line
00001000 00000080 00000001 00000010
00002010 00000001 00000001 00000001
00003000 00000400 00000008 00000080
00000ff0 00000209 00000005 00000042
12345678 00000088 00000002 00000011
0000fff8 00000100 00000002 00000020
80000000 00000008 00000001 00000001
00004000 00000a00 00000014 00000140
7fffff80 0000007f 00000001 00000010
